//--- hdl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int data_w     = 16;
    localparam int pc_w       = 32;
    localparam int reg_addr_w = 3;
    localparam int flag_w     = 3;

    // Flag vector layout, carry on top
    localparam int flag_c = 2;
    localparam int flag_n = 1;
    localparam int flag_z = 0;

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_not  = 4'd1,
        op_inc  = 4'd2,
        op_dec  = 4'd3,
        op_mov  = 4'd4,   // Passes operand B, so also load immediate
        op_add  = 4'd5,
        op_sub  = 4'd6,
        op_and  = 4'd7,
        op_or   = 4'd8,
        op_shl  = 4'd9,
        op_shr  = 4'd10,
        op_setc = 4'd11,
        op_clrc = 4'd12
    } alu_op_e;

    typedef enum logic [2:0] {
        jmp_none   = 3'd0,
        jmp_zero   = 3'd1,
        jmp_neg    = 3'd2,
        jmp_carry  = 3'd3,
        jmp_always = 3'd4
    } jump_cond_e;

endpackage

`default_nettype wire

//--- hdl/forwarding_unit.sv
`default_nettype none

module forwarding_unit #(
    parameter int reg_addr_w = ex_pkg::reg_addr_w
) (
    input  wire [reg_addr_w-1:0] rs_a,
    input  wire [reg_addr_w-1:0] rs_b,
    input  wire [reg_addr_w-1:0] ex_mem_rd,
    input  wire                  ex_mem_reg_write,
    input  wire                  ex_mem_valid,
    input  wire [reg_addr_w-1:0] mem_wb_rd,
    input  wire                  mem_wb_reg_write,
    output logic [1:0]           fwd_a_sel,
    output logic [1:0]           fwd_b_sel
);

    // 0 register file, 1 EX/MEM result, 2 write-back data
    function automatic logic [1:0] pick_source(input logic [reg_addr_w-1:0] rs);
        logic ex_hit;
        logic wb_hit;
        ex_hit = ex_mem_valid && ex_mem_reg_write && (ex_mem_rd == rs);
        wb_hit = mem_wb_reg_write && (mem_wb_rd == rs);
        if (ex_hit) begin
            pick_source = 2'd1;   // Younger producer wins
        end else if (wb_hit) begin
            pick_source = 2'd2;
        end else begin
            pick_source = 2'd0;
        end
    endfunction

    always_comb begin
        fwd_a_sel = pick_source(rs_a);
        fwd_b_sel = pick_source(rs_b);
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

module alu #(
    parameter int data_w = ex_pkg::data_w
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         valid,
    input  wire [data_w-1:0]            reg_a_data,
    input  wire [data_w-1:0]            reg_b_data,
    input  wire [data_w-1:0]            ex_mem_result,
    input  wire [data_w-1:0]            wb_data,
    input  wire [1:0]                   fwd_a_sel,
    input  wire [1:0]                   fwd_b_sel,
    input  wire [data_w-1:0]            imm,
    input  wire                         imm_select,
    input  wire [$clog2(data_w)-1:0]    shamt,
    input  wire ex_pkg::alu_op_e        alu_op,
    input  wire                         flag_enable,
    input  wire                         flag_restore,
    input  wire [ex_pkg::flag_w-1:0]    restored_flags,
    output logic [data_w-1:0]           op_a,
    output logic [data_w-1:0]           op_b,
    output logic [data_w-1:0]           result,
    output logic [ex_pkg::flag_w-1:0]   flags
);

    import ex_pkg::*;

    logic [data_w-1:0] fwd_b;
    logic              carry;
    logic [flag_w-1:0] next_flags;

    always_comb begin
        case (fwd_a_sel)
            2'd1:    op_a = ex_mem_result;
            2'd2:    op_a = wb_data;
            default: op_a = reg_a_data;
        endcase
        case (fwd_b_sel)
            2'd1:    fwd_b = ex_mem_result;
            2'd2:    fwd_b = wb_data;
            default: fwd_b = reg_b_data;
        endcase
    end

    assign op_b = imm_select ? imm : fwd_b;

    always_comb begin
        carry  = flags[flag_c];
        result = '0;
        case (alu_op)
            op_not: result = ~op_a;
            op_inc: {carry, result} = {1'b0, op_a} + {{data_w{1'b0}}, 1'b1};
            op_dec: {carry, result} = {1'b0, op_a} - {{data_w{1'b0}}, 1'b1};   // Borrow on zero
            op_mov: result = op_b;
            op_add: {carry, result} = {1'b0, op_a} + {1'b0, op_b};
            op_sub: {carry, result} = {1'b0, op_a} - {1'b0, op_b};
            op_and: result = op_a & op_b;
            op_or:  result = op_a | op_b;
            op_shl: begin
                result = op_a << shamt;
                // Last bit out lands above the msb
                if (shamt != '0) begin
                    {carry, result} = {1'b0, op_a} << shamt;
                end
            end
            op_shr: begin
                result = op_a >> shamt;
                if (shamt != '0) begin
                    {result, carry} = {op_a, 1'b0} >> shamt;
                end
            end
            op_setc: carry = 1'b1;
            op_clrc: carry = 1'b0;
            default: result = '0;
        endcase
    end

    always_comb begin
        next_flags         = flags;
        next_flags[flag_c] = carry;
        if (alu_op != op_nop && alu_op != op_setc && alu_op != op_clrc) begin
            next_flags[flag_n] = result[data_w-1];
            next_flags[flag_z] = (result == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (valid && flag_restore) begin
            flags <= restored_flags;   // Restore beats a normal update
        end else if (valid && flag_enable) begin
            flags <= next_flags;
        end
    end

endmodule

`default_nettype wire

//--- hdl/branch_controller.sv
`default_nettype none

module branch_controller #(
    parameter int pc_w   = ex_pkg::pc_w,
    parameter int data_w = ex_pkg::data_w
) (
    input  wire                       valid,
    input  wire ex_pkg::jump_cond_e   jump_cond,
    input  wire [ex_pkg::flag_w-1:0]  flags,
    input  wire [pc_w-1:0]            pc,
    input  wire [data_w-1:0]          target_operand,
    output logic                      branch_taken,
    output logic [pc_w-1:0]           new_pc
);

    import ex_pkg::*;

    logic cond_met;

    always_comb begin
        case (jump_cond)
            jmp_zero:   cond_met = flags[flag_z];
            jmp_neg:    cond_met = flags[flag_n];
            jmp_carry:  cond_met = flags[flag_c];
            jmp_always: cond_met = 1'b1;
            default:    cond_met = 1'b0;
        endcase
    end

    assign branch_taken = valid && cond_met;

    // Target comes from the destination register, sign extended
    assign new_pc = branch_taken ?
                    {{(pc_w-data_w){target_operand[data_w-1]}}, target_operand} : pc;

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`default_nettype none

module execute_stage #(
    parameter int data_w     = ex_pkg::data_w,
    parameter int pc_w       = ex_pkg::pc_w,
    parameter int reg_addr_w = ex_pkg::reg_addr_w
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire [pc_w-1:0]              pc,
    input  wire [data_w-1:0]            reg_a_data,
    input  wire [data_w-1:0]            reg_b_data,
    input  wire [reg_addr_w-1:0]        rs_a,
    input  wire [reg_addr_w-1:0]        rs_b,
    input  wire [reg_addr_w-1:0]        rd,
    input  wire [data_w-1:0]            imm,
    input  wire                         imm_select,
    input  wire [$clog2(data_w)-1:0]    shamt,
    input  wire ex_pkg::alu_op_e        alu_op,
    input  wire ex_pkg::jump_cond_e     jump_cond,
    input  wire                         flag_enable,
    input  wire                         flag_restore,
    input  wire [ex_pkg::flag_w-1:0]    restored_flags,
    input  wire                         reg_write,
    input  wire                         mem_read,
    input  wire                         mem_write,
    input  wire [1:0]                   wb_sel,
    input  wire [data_w-1:0]            wb_data,
    input  wire [reg_addr_w-1:0]        mem_wb_rd,
    input  wire                         mem_wb_reg_write,
    output logic                        out_valid,
    output logic [data_w-1:0]           result_out,
    output logic [data_w-1:0]           op_a_out,
    output logic [data_w-1:0]           op_b_out,
    output logic [reg_addr_w-1:0]       rd_out,
    output logic                        reg_write_out,
    output logic                        mem_read_out,
    output logic                        mem_write_out,
    output logic [1:0]                  wb_sel_out,
    output logic [pc_w-1:0]             pc_out,
    output logic [ex_pkg::flag_w-1:0]   flags,
    output logic                        branch_taken,
    output logic [pc_w-1:0]             new_pc
);

    logic [1:0]        fwd_a_sel;
    logic [1:0]        fwd_b_sel;
    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] result;

    // EX/MEM side comes straight from our own pipeline register
    forwarding_unit #(
        .reg_addr_w (reg_addr_w)
    ) u_fwd (
        .rs_a             (rs_a),
        .rs_b             (rs_b),
        .ex_mem_rd        (rd_out),
        .ex_mem_reg_write (reg_write_out),
        .ex_mem_valid     (out_valid),
        .mem_wb_rd        (mem_wb_rd),
        .mem_wb_reg_write (mem_wb_reg_write),
        .fwd_a_sel        (fwd_a_sel),
        .fwd_b_sel        (fwd_b_sel)
    );

    alu #(
        .data_w (data_w)
    ) u_alu (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid          (in_valid),
        .reg_a_data     (reg_a_data),
        .reg_b_data     (reg_b_data),
        .ex_mem_result  (result_out),
        .wb_data        (wb_data),
        .fwd_a_sel      (fwd_a_sel),
        .fwd_b_sel      (fwd_b_sel),
        .imm            (imm),
        .imm_select     (imm_select),
        .shamt          (shamt),
        .alu_op         (alu_op),
        .flag_enable    (flag_enable),
        .flag_restore   (flag_restore),
        .restored_flags (restored_flags),
        .op_a           (op_a),
        .op_b           (op_b),
        .result         (result),
        .flags          (flags)
    );

    // Sees flags before this instruction's own update
    branch_controller #(
        .pc_w   (pc_w),
        .data_w (data_w)
    ) u_branch (
        .valid          (in_valid),
        .jump_cond      (jump_cond),
        .flags          (flags),
        .pc             (pc),
        .target_operand (op_a),
        .branch_taken   (branch_taken),
        .new_pc         (new_pc)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid     <= 1'b0;
            reg_write_out <= 1'b0;
            mem_read_out  <= 1'b0;
            mem_write_out <= 1'b0;
        end else begin
            out_valid     <= in_valid;
            reg_write_out <= in_valid && reg_write;   // Bubbles write nothing
            mem_read_out  <= in_valid && mem_read;
            mem_write_out <= in_valid && mem_write;
        end
    end

    always_ff @(posedge clk) begin
        result_out <= result;
        op_a_out   <= op_a;
        op_b_out   <= op_b;
        rd_out     <= rd;
        wb_sel_out <= wb_sel;
        pc_out     <= pc;
    end

endmodule

`default_nettype wire

//--- tests/execute_stage_assertions.sv
`default_nettype none

module execute_stage_assertions (
    input wire clk,
    input wire rst_n,
    input wire in_valid,
    input wire out_valid,
    input wire reg_write_out,
    input wire mem_read_out,
    input wire mem_write_out
);

    // Pipeline register controls come out of reset low
    reset_clears_controls: assert property (@(posedge clk)
        !rst_n |=> (!out_valid && !reg_write_out && !mem_read_out && !mem_write_out))
        else $error("control outputs not cleared by reset");

    mem_access_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read_out && mem_write_out))
        else $error("mem_read_out and mem_write_out high together");

    valid_follows_input: assert property (@(posedge clk)
        (rst_n && $past(rst_n)) |-> (out_valid == $past(in_valid)))
        else $error("out_valid does not follow in_valid of the previous cycle");

endmodule

bind execute_stage execute_stage_assertions u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .out_valid     (out_valid),
    .reg_write_out (reg_write_out),
    .mem_read_out  (mem_read_out),
    .mem_write_out (mem_write_out)
);

`default_nettype wire

//--- tests/execute_stage_tb.sv
`default_nettype none

module execute_stage_tb;

    import ex_pkg::*;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              in_valid;
    logic [31:0]       pc;
    logic [15:0]       reg_a_data;
    logic [15:0]       reg_b_data;
    logic [2:0]        rs_a;
    logic [2:0]        rs_b;
    logic [2:0]        rd;
    logic [15:0]       imm;
    logic              imm_select;
    logic [3:0]        shamt;
    alu_op_e           alu_op;
    jump_cond_e        jump_cond;
    logic              flag_enable;
    logic              flag_restore;
    logic [2:0]        restored_flags;
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic [1:0]        wb_sel;
    logic [15:0]       wb_data;
    logic [2:0]        mem_wb_rd;
    logic              mem_wb_reg_write;
    logic              out_valid;
    logic [15:0]       result_out;
    logic [15:0]       op_a_out;
    logic [15:0]       op_b_out;
    logic [2:0]        rd_out;
    logic              reg_write_out;
    logic              mem_read_out;
    logic              mem_write_out;
    logic [1:0]        wb_sel_out;
    logic [31:0]       pc_out;
    logic [2:0]        flags;
    logic              branch_taken;
    logic [31:0]       new_pc;

    // Instruction waiting for its EX/MEM check
    logic              pend_valid;
    logic [127:0]      pend_name;
    logic [15:0]       pend_res;
    logic [2:0]        pend_flags;
    logic [2:0]        pend_rd;
    logic [15:0]       pend_op_a;
    logic [15:0]       pend_op_b;
    logic [31:0]       pend_pc;
    logic [2:0]        pend_ctl;
    logic [1:0]        pend_wb_sel;
    logic              pend_err;

    // Last issued slot as the next instruction sees it in EX/MEM
    logic              ex_valid;
    logic [2:0]        ex_rd;
    logic              ex_wr;
    logic [15:0]       ex_res;
    logic [2:0]        model_flags;

    int                errors = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;
    logic [31:0]       lfsr = 32'hcc83_eaa5;

    execute_stage #(.data_w(16), .pc_w(32), .reg_addr_w(3)) dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s >> 1;
        if (s[0]) lfsr_step = lfsr_step ^ 32'h8020_0003;
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // EX/MEM beats MEM/WB, register 0 included
    function automatic logic [15:0] forwarded_operand(input logic [2:0]  rs,
                                                      input logic [15:0] reg_val,
                                                      input logic [15:0] wb_val,
                                                      input logic [2:0]  wb_rd,
                                                      input logic        wb_wr);
        if (ex_valid && ex_wr && ex_rd == rs) begin
            forwarded_operand = ex_res;
        end else if (wb_wr && wb_rd == rs) begin
            forwarded_operand = wb_val;
        end else begin
            forwarded_operand = reg_val;
        end
    endfunction

    // Bubble carries live controls, none may act without in_valid
    task automatic drive_bubble();
        in_valid       <= 1'b0;
        reg_write      <= 1'b1;
        mem_read       <= 1'b1;
        flag_restore   <= 1'b1;
        restored_flags <= ~model_flags;
        jump_cond      <= jmp_always;
    endtask

    task automatic finish_pending();
        assert (out_valid) else begin
            $display("ERROR %0s out_valid expected 1 actual %b", pend_name, out_valid);
            pend_err = 1'b1;
        end
        assert (result_out == pend_res) else begin
            $display("ERROR %0s result expected %h actual %h", pend_name, pend_res, result_out);
            pend_err = 1'b1;
        end
        assert (flags == pend_flags) else begin
            $display("ERROR %0s flags expected %b actual %b", pend_name, pend_flags, flags);
            pend_err = 1'b1;
        end
        assert (rd_out == pend_rd) else begin
            $display("ERROR %0s rd expected %0d actual %0d", pend_name, pend_rd, rd_out);
            pend_err = 1'b1;
        end
        assert (op_a_out == pend_op_a) else begin
            $display("ERROR %0s op_a expected %h actual %h", pend_name, pend_op_a, op_a_out);
            pend_err = 1'b1;
        end
        assert (op_b_out == pend_op_b) else begin
            $display("ERROR %0s op_b expected %h actual %h", pend_name, pend_op_b, op_b_out);
            pend_err = 1'b1;
        end
        assert (pc_out == pend_pc) else begin
            $display("ERROR %0s pc_out expected %h actual %h", pend_name, pend_pc, pc_out);
            pend_err = 1'b1;
        end
        assert ({reg_write_out, mem_read_out, mem_write_out} == pend_ctl) else begin
            $display("ERROR %0s reg_wr/mem_rd/mem_wr expected %b actual %b", pend_name,
                     pend_ctl, {reg_write_out, mem_read_out, mem_write_out});
            pend_err = 1'b1;
        end
        assert (wb_sel_out == pend_wb_sel) else begin
            $display("ERROR %0s wb_sel expected %0d actual %0d", pend_name, pend_wb_sel,
                     wb_sel_out);
            pend_err = 1'b1;
        end
        if (pend_err) begin
            tests_failed++;
            $display("FAIL %0s", pend_name);
        end else begin
            tests_passed++;
            $display("PASS %0s", pend_name);
        end
        pend_valid = 1'b0;
    endtask

    task automatic bubble_cycle();
        @(posedge clk);
        drive_bubble();
        ex_valid = 1'b0;
        @(negedge clk);
        assert (!branch_taken) else begin
            $display("branch_taken went high during a bubble");
            errors++;
        end
        if (pend_valid) begin
            finish_pending();
        end else begin
            assert (!out_valid && !reg_write_out && !mem_read_out && !mem_write_out
                    && flags == model_flags) else begin
                $display("A bubble set EX/MEM controls or changed the flags");
                errors++;
            end
        end
    endtask

    // Watchdog on the whole run
    initial begin
        for (int i = 0; i < 2000; i++) @(posedge clk);
        $display("Timeout: run exceeded 2000 clock cycles");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        int          nb;
        int          wb_pick;
        string       line;
        logic [127:0] tname;
        logic [31:0] f [0:24];
        logic [15:0] exp_a;
        logic [15:0] exp_b;
        logic        cur_err;
        rst_n            = 1'b0;
        in_valid         = 1'b0;
        pc               = '0;
        reg_a_data       = '0;
        reg_b_data       = '0;
        rs_a             = '0;
        rs_b             = '0;
        rd               = '0;
        imm              = '0;
        imm_select       = 1'b0;
        shamt            = '0;
        alu_op           = op_nop;
        jump_cond        = jmp_none;
        flag_enable      = 1'b0;
        flag_restore     = 1'b0;
        restored_flags   = '0;
        reg_write        = 1'b0;
        mem_read         = 1'b0;
        mem_write        = 1'b0;
        wb_sel           = '0;
        wb_data          = '0;
        mem_wb_rd        = '0;
        mem_wb_reg_write = 1'b0;
        pend_valid       = 1'b0;
        pend_err         = 1'b0;
        ex_valid         = 1'b0;
        model_flags      = 3'b000;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!out_valid && !reg_write_out && !mem_read_out && !mem_write_out
                && !branch_taken && flags == 3'b000) else begin
            $display("Outputs not in their reset state after reset");
            errors++;
        end
        fd = $fopen("tests/execute_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/execute_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line.getc(0) == "#") continue;
                n = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            tname, f[0], f[1], f[2], f[3], f[4],
                            f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12], f[13], f[14],
                            f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23],
                            f[24]);
                if (n != 26) begin
                    $display("Malformed stimulus line: %0s", line);
                    errors++;
                    continue;
                end
                if (f[0][0]) begin   // Group start, random bubbles allowed
                    random_bits(2, nb);
                    for (int b = 0; b < nb; b++) bubble_cycle();
                end
                random_bits(2, wb_pick);
                exp_a = forwarded_operand(f[1][2:0], f[4][15:0], f[17][15:0],
                                          f[18][2:0], f[19][0]);
                exp_b = forwarded_operand(f[2][2:0], f[5][15:0], f[17][15:0],
                                          f[18][2:0], f[19][0]);
                if (f[7][0]) begin
                    exp_b = f[6][15:0];
                end
                @(posedge clk);
                in_valid         <= 1'b1;
                rs_a             <= f[1][2:0];
                rs_b             <= f[2][2:0];
                rd               <= f[3][2:0];
                reg_a_data       <= f[4][15:0];
                reg_b_data       <= f[5][15:0];
                imm              <= f[6][15:0];
                imm_select       <= f[7][0];
                shamt            <= f[8][3:0];
                alu_op           <= alu_op_e'(f[9][3:0]);
                jump_cond        <= jump_cond_e'(f[10][2:0]);
                flag_enable      <= f[11][0];
                flag_restore     <= f[12][0];
                restored_flags   <= f[13][2:0];
                reg_write        <= f[14][0];
                mem_read         <= f[15][0];
                mem_write        <= f[16][0];
                wb_data          <= f[17][15:0];
                mem_wb_rd        <= f[18][2:0];
                mem_wb_reg_write <= f[19][0];
                pc               <= f[20];
                wb_sel           <= wb_pick[1:0];
                @(negedge clk);
                cur_err = 1'b0;
                assert (branch_taken == f[23][0]) else begin
                    $display("ERROR %0s branch_taken expected %b actual %b",
                             tname, f[23][0], branch_taken);
                    cur_err = 1'b1;
                end
                assert (new_pc == f[24]) else begin
                    $display("ERROR %0s new_pc expected %h actual %h", tname, f[24], new_pc);
                    cur_err = 1'b1;
                end
                if (pend_valid) finish_pending();
                pend_valid  = 1'b1;
                pend_name   = tname;
                pend_res    = f[21][15:0];
                pend_flags  = f[22][2:0];
                pend_rd     = f[3][2:0];
                pend_op_a   = exp_a;
                pend_op_b   = exp_b;
                pend_pc     = f[20];
                pend_ctl    = {f[14][0], f[15][0], f[16][0]};
                pend_wb_sel = wb_pick[1:0];
                pend_err    = cur_err;
                ex_valid    = 1'b1;
                ex_rd       = f[3][2:0];
                ex_wr       = f[14][0];
                ex_res      = f[21][15:0];
                model_flags = f[22][2:0];
            end
            $fclose(fd);
        end
        bubble_cycle();
        bubble_cycle();
        $display("Tests passed %0d, tests failed %0d, other errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && tests_passed > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/execute_stimulus.txt
# name grp rs_a rs_b rd reg_a reg_b imm imm_sel shamt op jcond flag_en flag_rst rflags
#   reg_wr mem_rd mem_wr wb_data wb_rd wb_wr pc | exp: result flags br_taken new_pc (hex)
add_basic 1 1 2 1 0003 0004 0000 0 0 5 0 1 0 0 0 1 0 0000 0 0 00001001 0007 0 0 00001001
add_carry 1 1 2 1 ffff 0001 0000 0 0 5 0 1 0 0 0 0 1 0000 0 0 00001002 0000 5 0 00001002
sub_borrow 1 1 2 1 0002 0005 0000 0 0 6 0 1 0 0 0 0 0 0000 0 0 00001003 fffd 6 0 00001003
sub_zero 1 1 2 1 0009 0009 0000 0 0 6 0 1 0 0 0 0 0 0000 0 0 00001004 0000 1 0 00001004
and_op 1 1 2 1 f0f0 0ff0 0000 0 0 7 0 1 0 0 0 0 0 0000 0 0 00001005 00f0 0 0 00001005
or_op 1 1 2 1 8000 0001 0000 0 0 8 0 1 0 0 0 0 0 0000 0 0 00001006 8001 2 0 00001006
not_op 1 1 2 1 00ff 0000 0000 0 0 1 0 1 0 0 0 0 0 0000 0 0 00001007 ff00 2 0 00001007
inc_op 1 1 2 1 7fff 0000 0000 0 0 2 0 1 0 0 0 0 0 0000 0 0 00001008 8000 2 0 00001008
dec_zero 1 1 2 1 0000 0000 0000 0 0 3 0 1 0 0 0 0 0 0000 0 0 00001009 ffff 6 0 00001009
mov_imm 1 1 2 1 0000 0000 1234 1 0 4 0 1 0 0 0 0 0 0000 0 0 0000100a 1234 4 0 0000100a
add_imm 1 1 2 1 0010 0000 0020 1 0 5 0 1 0 0 0 0 0 0000 0 0 0000100b 0030 0 0 0000100b
shl_one 1 1 2 1 8001 0000 0000 0 1 9 0 1 0 0 0 0 0 0000 0 0 0000100c 0002 4 0 0000100c
shr_one 1 1 2 1 0003 0000 0000 0 1 a 0 1 0 0 0 0 0 0000 0 0 0000100d 0001 4 0 0000100d
shl_four 1 1 2 1 0f00 0000 0000 0 4 9 0 1 0 0 0 0 0 0000 0 0 0000100e f000 2 0 0000100e
set_carry 1 1 2 1 0000 0000 0000 0 0 b 0 1 0 0 0 0 0 0000 0 0 0000100f 0000 6 0 0000100f
clr_carry 1 1 2 1 0000 0000 0000 0 0 c 0 1 0 0 0 0 0 0000 0 0 00001010 0000 2 0 00001010
br_neg_taken 1 1 2 1 8040 0000 0000 0 0 0 2 0 0 0 0 0 0 0000 0 0 00001011 0000 2 1 ffff8040
br_zero_not 1 1 2 1 0040 0000 0000 0 0 0 1 0 0 0 0 0 0 0000 0 0 00001012 0000 2 0 00001012
br_carry_not 1 1 2 1 0040 0000 0000 0 0 0 3 0 0 0 0 0 0 0000 0 0 00001013 0000 2 0 00001013
make_zero 1 1 2 1 0005 0005 0000 0 0 6 0 1 0 0 0 0 0 0000 0 0 00001014 0000 1 0 00001014
br_zero_taken 1 1 2 1 0100 0000 0000 0 0 0 1 0 0 0 0 0 0 0000 0 0 00001015 0000 1 1 00000100
br_always 1 1 2 1 0200 0000 0000 0 0 0 4 0 0 0 0 0 0 0000 0 0 00001016 0000 1 1 00000200
set_carry_again 1 1 2 1 0000 0000 0000 0 0 b 0 1 0 0 0 0 0 0000 0 0 00001017 0000 5 0 00001017
br_carry_taken 1 1 2 1 0300 0000 0000 0 0 0 3 0 0 0 0 0 0 0000 0 0 00001018 0000 5 1 00000300
fwd_producer 1 1 2 2 0005 0003 0000 0 0 5 0 1 0 0 1 0 0 0000 0 0 00001019 0008 0 0 00001019
fwd_ex_mem 0 2 3 3 1111 0001 0000 0 0 5 0 1 0 0 1 0 0 0000 0 0 0000101a 0009 0 0 0000101a
fwd_mem_wb 0 2 4 2 2222 0002 0000 0 0 5 0 1 0 0 1 0 0 0008 2 1 0000101b 000a 0 0 0000101b
fwd_both 0 2 6 1 3333 0001 0000 0 0 5 0 1 0 0 0 0 0 0009 2 1 0000101c 000b 0 0 0000101c
flag_restore 1 0 0 1 0000 0000 0000 0 0 0 0 0 1 6 0 0 0 0000 0 0 0000101d 0000 6 0 0000101d

//--- files.f
hdl/ex_pkg.sv
hdl/forwarding_unit.sv
hdl/alu.sv
hdl/branch_controller.sv
hdl/execute_stage.sv
tests/execute_stage_assertions.sv
tests/execute_stage_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module execute_stage_tb -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
